/* logic/coreDefs.svh */
// Core sizing macros: datapath width, register count and memory depths
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and instruction word
`define WORD_WIDTH 16

// General purpose registers R0..R7
`define REG_COUNT 8

// Instruction fields
`define OPCODE_WIDTH 5      // Bits 15..11
`define REG_IDX_WIDTH 3     // Rs, Rt and Rd fields

// Memory sizes in 16-bit words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// Link register for jal and jalr
`define LINK_REG 7

`endif

/* logic/corePkg.sv */
// Core types: data word, register index, opcodes and datapath selectors
package corePkg;
    `include "coreDefs.svh"

    typedef logic [`WORD_WIDTH-1:0] wordT;       // Data and instruction word
    typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;  // R0..R7

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opHalt   = 5'b00000,
        opNop    = 5'b00001,
        opJ      = 5'b00100,
        opJr     = 5'b00101,
        opJal    = 5'b00110,
        opJalr   = 5'b00111,
        opAddi   = 5'b01000,
        opSubi   = 5'b01001,
        opXori   = 5'b01010,
        opAndni  = 5'b01011,
        opBeqz   = 5'b01100,
        opBnez   = 5'b01101,
        opBltz   = 5'b01110,
        opSt     = 5'b10000,
        opLd     = 5'b10001,
        opStu    = 5'b10011,
        opRArith = 5'b11011   // Function in bits 1..0
    } opcodeT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluXor, aluAndn, aluPassB} aluOpT;
    typedef enum logic [1:0] {wsRdR, wsRdI1, wsRs, wsLink} writeSelT;
    typedef enum logic [1:0] {imm5, imm8, disp11} immSelT;
    typedef enum logic [1:0] {pcSeq, pcBranch, pcJumpDisp, pcJumpReg} pcSelT;
endpackage

/* logic/fetchStage.sv */
// Fetch stage: PC register with halt hold, loadable instruction memory and PC + 2
`timescale 1ns/100ps
`include "coreDefs.svh"
module fetchStage import corePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic haltReq,       // Halt or illegal opcode at pc
    input  wordT nextPc,
    input  logic imemLoadEn,
    input  wordT imemLoadAddr,  // Word index, not byte address
    input  wordT imemLoadData,
    output wordT pc,
    output wordT instr,
    output wordT pcPlus2,
    output logic halted
);
    localparam int imemAddrW = $clog2(`IMEM_DEPTH);

    wordT imem [`IMEM_DEPTH];  // Program store

    always_ff @(posedge clk) begin
        if (imemLoadEn && !rstN) begin  // Loading only while the core is held
            imem[imemLoadAddr[imemAddrW-1:0]] <= imemLoadData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (haltReq) begin
            halted <= 1'b1;    // Sticky until reset, pc frozen
        end else begin
            pc <= nextPc;
        end
    end

    assign instr   = imem[pc[imemAddrW:1]];  // Byte PC, word memory
    assign pcPlus2 = pc + wordT'(2);
endmodule

/* logic/controlDecoder.sv */
// Control decoder: opcode and R-format function to datapath controls
`timescale 1ns/100ps
module controlDecoder import corePkg::*; (
    input  wordT     instr,
    output writeSelT writeSel,
    output immSelT   immSel,
    output logic     zeroExt,
    output logic     aluSrc,
    output logic     regWrite,
    output logic     memWrite,
    output logic     memRead,
    output logic     halt,
    output logic     illegal,
    output aluOpT    aluOp,
    output pcSelT    pcSel
);
    opcodeT opcode;
    logic [1:0] funct;

    assign opcode = opcodeT'(instr[15:11]);
    assign funct  = instr[1:0];  // R-format extension

    always_comb begin
        // Quiet defaults, nothing written and pc sequential
        writeSel = wsRdI1;
        immSel   = imm5;
        zeroExt  = 1'b0;
        aluSrc   = 1'b0;
        aluOp    = aluPassB;
        regWrite = 1'b0;
        memWrite = 1'b0;
        memRead  = 1'b0;
        pcSel    = pcSeq;
        halt     = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            opHalt: halt = 1'b1;
            opNop: ;
            opJ: begin
                immSel = disp11;
                pcSel  = pcJumpDisp;
            end
            opJal: begin
                immSel   = disp11;
                pcSel    = pcJumpDisp;
                writeSel = wsLink;  // R7 gets pc + 2
                regWrite = 1'b1;
            end
            opJr: begin
                immSel = imm8;
                pcSel  = pcJumpReg;
            end
            opJalr: begin
                immSel   = imm8;
                pcSel    = pcJumpReg;
                writeSel = wsLink;
                regWrite = 1'b1;
            end
            opAddi, opSubi, opXori, opAndni: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                zeroExt  = (opcode == opXori) || (opcode == opAndni);  // Logical ops
                case (opcode)
                    opAddi:  aluOp = aluAdd;
                    opSubi:  aluOp = aluSub;  // imm - Rs
                    opXori:  aluOp = aluXor;
                    default: aluOp = aluAndn;
                endcase
            end
            opBeqz, opBnez, opBltz: begin
                immSel = imm8;
                pcSel  = pcBranch;  // Condition resolved in execute
            end
            opSt: begin
                aluSrc   = 1'b1;
                aluOp    = aluAdd;  // Rs + imm address
                memWrite = 1'b1;
            end
            opLd: begin
                aluSrc   = 1'b1;
                aluOp    = aluAdd;
                memRead  = 1'b1;
                regWrite = 1'b1;
            end
            opStu: begin
                aluSrc   = 1'b1;
                aluOp    = aluAdd;
                memWrite = 1'b1;
                regWrite = 1'b1;
                writeSel = wsRs;    // Base register updated
            end
            opRArith: begin
                writeSel = wsRdR;
                regWrite = 1'b1;
                case (funct)
                    2'b00:   aluOp = aluAdd;
                    2'b01:   aluOp = aluSub;  // Rt - Rs
                    2'b10:   aluOp = aluXor;
                    default: aluOp = aluAndn;
                endcase
            end
            default: illegal = 1'b1;  // Unknown opcode, stops the core
        endcase
    end
endmodule

/* logic/regFile.sv */
// Register file: eight words, two combinational reads and one clocked write
`timescale 1ns/100ps
`include "coreDefs.svh"
module regFile import corePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   writeEn,
    input  regIdxT read1Sel,
    input  regIdxT read2Sel,
    input  regIdxT writeSel,
    input  wordT   writeData,
    output wordT   read1Data,
    output wordT   read2Data
);
    wordT regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;  // All registers start at zero
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Reads see the value from before this edge
    assign read1Data = regs[read1Sel];
    assign read2Data = regs[read2Sel];
endmodule

/* logic/decodeStage.sv */
// Decode stage with write register and link selection, immediate extension and register file
`timescale 1ns/100ps
`include "coreDefs.svh"
module decodeStage import corePkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  wordT     instr,
    input  wordT     pcPlus2,
    input  wordT     wbData,    // ALU result or load data
    input  writeSelT writeSel,
    input  immSelT   immSel,
    input  logic     zeroExt,
    input  logic     regWrite,
    output wordT     rsData,
    output wordT     rtData,    // Rt in R-format and Rd in I-format-1 stores
    output wordT     immVal,
    output regIdxT   writeReg,
    output wordT     writeData
);
    localparam int w = `WORD_WIDTH;

    regIdxT rsIdx;
    regIdxT rtIdx;

    assign rsIdx = instr[10:8];
    assign rtIdx = instr[7:5];

    always_comb begin
        case (writeSel)
            wsRdR:   writeReg = instr[4:2];
            wsRdI1:  writeReg = rtIdx;
            wsRs:    writeReg = rsIdx;            // stu base update
            default: writeReg = regIdxT'(`LINK_REG);
        endcase
    end

    assign writeData = (writeSel == wsLink) ? pcPlus2 : wbData;  // Return address

    always_comb begin
        case (immSel)
            imm5: begin
                if (zeroExt) immVal = {{(w-5){1'b0}}, instr[4:0]};
                else         immVal = {{(w-5){instr[4]}}, instr[4:0]};
            end
            imm8:    immVal = {{(w-8){instr[7]}}, instr[7:0]};  // Branch offset
            default: immVal = {{(w-11){instr[10]}}, instr[10:0]};  // Jump displacement
        endcase
    end

    regFile regFile0 (
        .clk       (clk),
        .rstN      (rstN),
        .writeEn   (regWrite),
        .read1Sel  (rsIdx),
        .read2Sel  (rtIdx),
        .writeSel  (writeReg),
        .writeData (writeData),
        .read1Data (rsData),
        .read2Data (rtData)
    );
endmodule

/* logic/executeStage.sv */
// Execute stage: ALU, branch condition and next-PC selection
`timescale 1ns/100ps
module executeStage import corePkg::*; (
    input  wordT   rsData,
    input  wordT   rtData,
    input  wordT   immVal,
    input  wordT   pcPlus2,
    input  aluOpT  aluOp,
    input  logic   aluSrc,      // 1 selects the immediate
    input  pcSelT  pcSel,
    input  opcodeT branchKind,  // Which branch condition
    output wordT   aluResult,
    output wordT   nextPc
);
    wordT opB;
    logic taken;
    wordT pcRel;

    assign opB = aluSrc ? immVal : rtData;

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = rsData + opB;
            aluSub:  aluResult = opB - rsData;   // Second operand minus Rs
            aluXor:  aluResult = rsData ^ opB;
            aluAndn: aluResult = rsData & ~opB;
            default: aluResult = opB;
        endcase
    end

    always_comb begin
        case (branchKind)
            opBeqz:  taken = (rsData == '0);
            opBnez:  taken = (rsData != '0);
            opBltz:  taken = rsData[$bits(wordT)-1];  // Sign bit
            default: taken = 1'b0;
        endcase
    end

    assign pcRel = pcPlus2 + immVal;  // Shared by branches and j/jal

    always_comb begin
        case (pcSel)
            pcBranch:   nextPc = taken ? pcRel : pcPlus2;
            pcJumpDisp: nextPc = pcRel;
            pcJumpReg:  nextPc = rsData + immVal;
            default:    nextPc = pcPlus2;
        endcase
    end
endmodule

/* logic/memAccess.sv */
// Memory stage: word data memory with clocked store, async load and write-back mux
`timescale 1ns/100ps
`include "coreDefs.svh"
module memAccess import corePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic memWrite,
    input  logic memRead,
    input  wordT aluResult,  // Byte address for st, ld, stu
    input  wordT storeData,
    output wordT wbData
);
    localparam int dmemAddrW = $clog2(`DMEM_DEPTH);

    wordT dmem [`DMEM_DEPTH];
    logic [dmemAddrW-1:0] wordAddr;

    assign wordAddr = aluResult[dmemAddrW:1];  // Drop byte bit

    always_ff @(posedge clk) begin
        if (memWrite && rstN) begin  // No stores while held in reset
            dmem[wordAddr] <= storeData;
        end
    end

    // Old contents seen on a same-cycle read
    assign wbData = memRead ? dmem[wordAddr] : aluResult;
endmodule

/* logic/coreTop.sv */
// Single-cycle core top: stage wiring, program load port and write-back trace
`timescale 1ns/100ps
module coreTop import corePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   imemLoadEn,
    input  wordT   imemLoadAddr,
    input  wordT   imemLoadData,
    output wordT   pc,
    output logic   wbValid,
    output regIdxT wbReg,
    output wordT   wbData,
    output logic   halted
);
    wordT     instr;
    wordT     pcPlus2;
    wordT     nextPc;
    writeSelT writeSel;
    immSelT   immSel;
    logic     zeroExt;
    logic     aluSrc;
    aluOpT    aluOp;
    logic     regWrite;
    logic     memWrite;
    logic     memRead;
    pcSelT    pcSel;
    logic     halt;
    logic     illegal;
    logic     haltReq;
    opcodeT   opcode;
    wordT     rsData;
    wordT     rtData;
    wordT     immVal;
    wordT     aluResult;
    wordT     memWbData;  // Before link override

    assign haltReq = halt | illegal;
    assign opcode  = opcodeT'(instr[15:11]);
    assign wbValid = regWrite;

    fetchStage fetch0 (
        .clk (clk), .rstN (rstN), .haltReq (haltReq), .nextPc (nextPc),
        .imemLoadEn (imemLoadEn), .imemLoadAddr (imemLoadAddr),
        .imemLoadData (imemLoadData),
        .pc (pc), .instr (instr), .pcPlus2 (pcPlus2), .halted (halted)
    );

    controlDecoder ctrl0 (
        .instr (instr), .writeSel (writeSel), .immSel (immSel), .zeroExt (zeroExt),
        .aluSrc (aluSrc), .regWrite (regWrite), .memWrite (memWrite),
        .memRead (memRead), .halt (halt), .illegal (illegal), .aluOp (aluOp),
        .pcSel (pcSel)
    );

    decodeStage decode0 (
        .clk (clk), .rstN (rstN), .instr (instr), .pcPlus2 (pcPlus2),
        .wbData (memWbData), .writeSel (writeSel), .immSel (immSel),
        .zeroExt (zeroExt), .regWrite (regWrite),
        .rsData (rsData), .rtData (rtData), .immVal (immVal),
        .writeReg (wbReg), .writeData (wbData)  // Trace shows the final write
    );

    executeStage execute0 (
        .rsData (rsData), .rtData (rtData), .immVal (immVal), .pcPlus2 (pcPlus2),
        .aluOp (aluOp), .aluSrc (aluSrc), .pcSel (pcSel), .branchKind (opcode),
        .aluResult (aluResult), .nextPc (nextPc)
    );

    memAccess mem0 (
        .clk (clk), .rstN (rstN), .memWrite (memWrite), .memRead (memRead),
        .aluResult (aluResult), .storeData (rtData),  // Rd field holds store data
        .wbData (memWbData)
    );
endmodule

/* sim/coreTb.sv */
// Core testbench: loads programs, steps an ISA reference model and checks the trace by assertions
`timescale 1ns/100ps
`include "coreDefs.svh"
module coreTb;
    typedef logic [`WORD_WIDTH-1:0] wordT;

    localparam int resetCycles = 8;    // Reset span after the load
    localparam int holdCycles  = 4;    // Edges watched once halted
    localparam int imemAw = $clog2(`IMEM_DEPTH);
    localparam int dmemAw = $clog2(`DMEM_DEPTH);

    // ISA opcodes, bits 15..11
    localparam logic [4:0] opcHalt  = 5'b00000;
    localparam logic [4:0] opcNop   = 5'b00001;
    localparam logic [4:0] opcJ     = 5'b00100;
    localparam logic [4:0] opcJr    = 5'b00101;
    localparam logic [4:0] opcJal   = 5'b00110;
    localparam logic [4:0] opcJalr  = 5'b00111;
    localparam logic [4:0] opcAddi  = 5'b01000;
    localparam logic [4:0] opcSubi  = 5'b01001;
    localparam logic [4:0] opcXori  = 5'b01010;
    localparam logic [4:0] opcAndni = 5'b01011;
    localparam logic [4:0] opcBeqz  = 5'b01100;
    localparam logic [4:0] opcBnez  = 5'b01101;
    localparam logic [4:0] opcBltz  = 5'b01110;
    localparam logic [4:0] opcSt    = 5'b10000;
    localparam logic [4:0] opcLd    = 5'b10001;
    localparam logic [4:0] opcStu   = 5'b10011;
    localparam logic [4:0] opcArith = 5'b11011;

    logic clk;
    logic rstN;
    logic imemLoadEn;
    wordT imemLoadAddr;
    wordT imemLoadData;
    wordT pc;
    logic wbValid;
    logic [2:0] wbReg;
    wordT wbData;
    logic halted;

    int seed = 32'he9f7737e;
    int cycleCount = 0;
    int timeoutLimit;
    wordT prog1 [$];
    wordT prog2 [$];

    // Reference model state
    wordT progImage [`IMEM_DEPTH];  // Mirror of every loaded word
    wordT mRegs [`REG_COUNT];
    wordT mDmem [`DMEM_DEPTH];
    wordT mPc;
    logic mHalted;

    // Model decode of the current instruction
    wordT curInstr;
    wordT rsV;
    wordT rdV;                      // Rt in R-format, Rd in I-format-1
    wordT sImm5;
    wordT zImm5;
    wordT sImm8;
    wordT sDisp11;
    wordT memAddr;
    wordT expNextPc;
    logic expWbValid;
    logic [2:0] expWbReg;
    wordT expWbData;
    logic expHalt;
    logic storeEn;

    coreTop dut0 (
        .clk (clk), .rstN (rstN), .imemLoadEn (imemLoadEn),
        .imemLoadAddr (imemLoadAddr), .imemLoadData (imemLoadData),
        .pc (pc), .wbValid (wbValid), .wbReg (wbReg), .wbData (wbData), .halted (halted)
    );

    always #10 clk = ~clk;  // 20 ns period

    always_comb begin
        curInstr   = progImage[mPc[imemAw:1]];  // pc counts bytes
        rsV        = mRegs[curInstr[10:8]];
        rdV        = mRegs[curInstr[7:5]];
        sImm5      = {{11{curInstr[4]}}, curInstr[4:0]};
        zImm5      = {11'b0, curInstr[4:0]};
        sImm8      = {{8{curInstr[7]}}, curInstr[7:0]};
        sDisp11    = {{5{curInstr[10]}}, curInstr[10:0]};
        memAddr    = rsV + sImm5;
        expNextPc  = mPc + 16'd2;
        expWbValid = 1'b0;
        expWbReg   = curInstr[7:5];
        expWbData  = '0;
        expHalt    = 1'b0;
        storeEn    = 1'b0;
        case (curInstr[15:11])
            opcHalt: expHalt = 1'b1;
            opcNop: ;
            opcJ: expNextPc = mPc + 16'd2 + sDisp11;
            opcJal: begin
                expNextPc  = mPc + 16'd2 + sDisp11;
                expWbValid = 1'b1;
                expWbReg   = 3'd7;              // Return address in R7
                expWbData  = mPc + 16'd2;
            end
            opcJr: expNextPc = rsV + sImm8;
            opcJalr: begin
                expNextPc  = rsV + sImm8;       // Old R7 when Rs is R7
                expWbValid = 1'b1;
                expWbReg   = 3'd7;
                expWbData  = mPc + 16'd2;
            end
            opcAddi, opcSubi, opcXori, opcAndni: begin
                expWbValid = 1'b1;
                case (curInstr[12:11])
                    2'b00:   expWbData = rsV + sImm5;
                    2'b01:   expWbData = sImm5 - rsV;
                    2'b10:   expWbData = rsV ^ zImm5;
                    default: expWbData = rsV & ~zImm5;
                endcase
            end
            opcBeqz: if (rsV == '0) expNextPc = mPc + 16'd2 + sImm8;
            opcBnez: if (rsV != '0) expNextPc = mPc + 16'd2 + sImm8;
            opcBltz: if (rsV[15]) expNextPc = mPc + 16'd2 + sImm8;
            opcSt: storeEn = 1'b1;
            opcLd: begin
                expWbValid = 1'b1;
                expWbData  = mDmem[memAddr[dmemAw:1]];
            end
            opcStu: begin
                storeEn    = 1'b1;
                expWbValid = 1'b1;
                expWbReg   = curInstr[10:8];    // Base gets the address
                expWbData  = memAddr;
            end
            opcArith: begin
                expWbValid = 1'b1;
                expWbReg   = curInstr[4:2];
                case (curInstr[1:0])
                    2'b00:   expWbData = rsV + rdV;
                    2'b01:   expWbData = rdV - rsV;
                    2'b10:   expWbData = rsV ^ rdV;
                    default: expWbData = rsV & ~rdV;
                endcase
            end
            default: expHalt = 1'b1;            // Illegal opcode stops the core
        endcase
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mPc     <= '0;
            mHalted <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                mRegs[i] <= '0;
            end
        end else if (!mHalted) begin
            if (expHalt) begin
                mHalted <= 1'b1;                // pc stays on the stopping word
            end else begin
                mPc <= expNextPc;
                if (expWbValid) mRegs[expWbReg] <= expWbData;
                if (storeEn) mDmem[memAddr[dmemAw:1]] <= rdV;
            end
        end
    end

    task automatic reportMismatch(input string name, input wordT got, input wordT exp);
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1, "Trace mismatch on %s", name);
    endtask

    pcMatch: assert property (@(posedge clk) disable iff (!rstN) pc == mPc)
        else reportMismatch("pc", $sampled(pc), $sampled(mPc));
    haltedMatch: assert property (@(posedge clk) disable iff (!rstN) halted == mHalted)
        else reportMismatch("halted", 16'($sampled(halted)), 16'($sampled(mHalted)));
    wbValidMatch: assert property (@(posedge clk) disable iff (!rstN) wbValid == expWbValid)
        else reportMismatch("wbValid", 16'($sampled(wbValid)), 16'($sampled(expWbValid)));
    wbRegMatch: assert property (@(posedge clk) disable iff (!rstN)
            !expWbValid || wbReg == expWbReg)
        else reportMismatch("wbReg", 16'($sampled(wbReg)), 16'($sampled(expWbReg)));
    wbDataMatch: assert property (@(posedge clk) disable iff (!rstN)
            !expWbValid || wbData == expWbData)
        else reportMismatch("wbData", $sampled(wbData), $sampled(expWbData));

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout: core did not halt within %0d cycles", timeoutLimit);
            $display("SIMULATION FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic wordT encodeR(input int rs, input int rt, input int rd,
                                     input logic [1:0] fn);
        return {opcArith, 3'(rs), 3'(rt), 3'(rd), fn};
    endfunction

    function automatic wordT encodeI1(input logic [4:0] op, input int rs, input int rd,
                                      input logic [4:0] imm);
        return {op, 3'(rs), 3'(rd), imm};
    endfunction

    function automatic wordT encodeI2(input logic [4:0] op, input int rs, input logic [7:0] imm);
        return {op, 3'(rs), imm};
    endfunction

    function automatic wordT encodeJ(input logic [4:0] op, input logic [10:0] disp);
        return {op, disp};
    endfunction

    task automatic buildPrograms();
        logic [4:0] rnd [5];
        for (int i = 0; i < 5; i++) begin
            rnd[i] = 5'($random(seed));
        end
        prog1 = '{
            encodeI1(opcAddi, 0, 1, rnd[0]),            // pc 0
            encodeI1(opcAddi, 0, 2, rnd[1] | 5'h10),    // Negative immediate
            encodeI1(opcSubi, 1, 3, rnd[2] | 5'h10),
            encodeI1(opcXori, 2, 4, rnd[3] | 5'h10),    // Top bit set, zero extended
            encodeI1(opcAndni, 3, 5, rnd[4] | 5'h10),
            encodeR(1, 2, 6, 2'b00),                    // pc 10 add
            encodeR(4, 2, 6, 2'b01),                    // r6 = r2 - r4
            encodeR(3, 5, 1, 2'b10),
            encodeR(6, 4, 2, 2'b11),                    // r2 = r6 & ~r4
            encodeI1(opcSt, 0, 1, 5'd4),
            encodeI1(opcSt, 0, 6, 5'd6),                // pc 20
            encodeI1(opcLd, 0, 3, 5'd4),
            encodeI1(opcLd, 0, 4, 5'd6),
            encodeI1(opcAddi, 0, 5, 5'd8),
            encodeI1(opcStu, 5, 2, 5'd2),               // r5 becomes 10
            encodeI1(opcStu, 5, 3, 5'h1e),              // pc 30, r5 back to 8
            encodeI1(opcLd, 5, 6, 5'd2),
            encodeI1(opcAddi, 0, 1, 5'd3),
            encodeI1(opcAddi, 0, 2, 5'd1),
            encodeI1(opcAddi, 0, 3, 5'h1e),
            encodeI1(opcAddi, 1, 1, 5'h1f),             // pc 40 countdown loop
            encodeI2(opcBnez, 1, 8'hfc),
            encodeI1(opcXori, 2, 2, 5'd1),              // pc 44 toggle loop
            encodeI2(opcBeqz, 2, 8'hfc),
            encodeI1(opcAddi, 3, 3, 5'd1),              // pc 48 climb to zero
            encodeI2(opcBltz, 3, 8'hfc),
            encodeJ(opcJal, 11'd4),                     // pc 52 call to 58
            encodeJ(opcJ, 11'd8),                       // Skip to 64
            encodeJ(opcHalt, 11'd0),                    // Trap, never reached
            encodeI1(opcAddi, 4, 4, 5'd5),
            encodeI2(opcJr, 7, 8'd0),                   // pc 60 return to 54
            encodeJ(opcHalt, 11'd0),
            encodeI2(opcJalr, 7, 8'd18),                // pc 64 to 72, R7 = 66
            encodeR(4, 7, 1, 2'b00),
            encodeJ(opcJ, 11'd6),                       // To 76
            encodeJ(opcHalt, 11'd0),
            encodeR(4, 7, 2, 2'b01),                    // pc 72
            encodeI2(opcJr, 7, 8'd0),
            encodeI1(opcSt, 0, 1, 5'd12),               // pc 76
            encodeI1(opcLd, 0, 3, 5'd12),
            encodeJ(opcHalt, 11'd0),                    // pc 80
            encodeI1(opcAddi, 0, 1, 5'd1)               // Must never retire
        };
        prog2 = '{
            encodeI1(opcAddi, 0, 1, rnd[4]),
            encodeR(1, 1, 2, 2'b00),
            encodeJ(5'b11111, 11'd0),                   // Unknown opcode
            encodeI1(opcAddi, 0, 3, 5'd1),
            encodeJ(opcHalt, 11'd0)
        };
    endtask

    task automatic runPass(input int which);
        wordT image [$];
        if (which == 1) image = prog1;
        else image = prog2;
        @(posedge clk);
        #2 rstN = 1'b0;                                 // Core held while loading
        for (int i = 0; i < image.size(); i++) begin
            imemLoadEn   = 1'b1;
            imemLoadAddr = wordT'(i);                   // Word index
            imemLoadData = image[i];
            progImage[i] = image[i];
            @(posedge clk);
            #2;
        end
        imemLoadEn = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2 rstN = 1'b1;
        while (!halted) begin
            @(posedge clk);
            #2;
        end
        repeat (holdCycles) @(posedge clk);             // pc and trace stay frozen
    endtask

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        imemLoadEn   = 1'b0;
        imemLoadAddr = '0;
        imemLoadData = '0;
        buildPrograms();
        // Four cycles per instruction, plus each load and reset span
        timeoutLimit = 4 * (prog1.size() + prog2.size())
                     + prog1.size() + prog2.size() + 2 * (resetCycles + 2);
        runPass(1);
        runPass(2);                                     // Illegal opcode program
        $display("SIMULATION PASSED");
        $finish;
    end
endmodule

/* sources.f */
+incdir+logic
logic/corePkg.sv
logic/fetchStage.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memAccess.sv
logic/coreTop.sv
sim/coreTb.sv

/* Makefile */
# Verilator build and run of the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
